// File: sources.f
source/gfx_pkg.sv
source/gfx_regs.sv
source/layer_unit.sv
source/layer_mixer.sv
source/gfx_top.sv
testbench/tb_clock.sv
testbench/gfx_properties.sv
testbench/tb_gfx.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_gfx
LOG        ?= sim.log
NUM_LAYERS ?= 3
BUILD_DIR  ?= obj_dir
FILELIST   ?= sources.f

VFLAGS   ?= --binary --timing --assert --timescale 1ns/1ps -Gnum_layers=$(NUM_LAYERS)
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps \
		-Gnum_layers=$(NUM_LAYERS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_gfx.sv
`default_nettype none

module tb_gfx #(
    parameter int num_layers = 3
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 100;
    localparam int scan_len     = 320;
    localparam int active_len   = 256;
    localparam int num_steps    = 35;
    // Longest step is a full tile pass at the largest layer count
    localparam int entry_cycles = 2 * gfx_pkg::max_layers * gfx_pkg::tiles_per_row + scan_len;
    localparam int timeout_ns   = (num_steps + 4) * entry_cycles * clk_period;

    typedef enum logic [2:0] {
        op_write, op_read, op_fill, op_tiles, op_scan, op_vblank, op_irq
    } op_t;

    // exp holds read data, or the irq_n level for vblank and irq steps
    typedef struct packed {
        op_t         op;
        logic [11:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp;
    } step_t;

    step_t steps [num_steps] = '{
        '{op_read,   12'h000, 8'h00, 8'h00}, '{op_read,   12'h008, 8'h00, 8'h00},
        '{op_read,   12'h009, 8'h00, 8'hFF}, '{op_read,   12'h00A, 8'h00, 8'h00},
        '{op_read,   12'h00B, 8'h00, 8'h00}, '{op_write,  12'h000, 8'h13, 8'h00},
        '{op_write,  12'h001, 8'h5A, 8'h00}, '{op_write,  12'h002, 8'hC7, 8'h00},
        '{op_write,  12'h008, 8'h9E, 8'h00}, '{op_read,   12'h000, 8'h00, 8'h13},
        '{op_read,   12'h001, 8'h00, 8'h5A}, '{op_read,   12'h002, 8'h00, 8'hC7},
        '{op_read,   12'h008, 8'h00, 8'h9E}, '{op_write,  12'h00C, 8'h55, 8'h00},
        '{op_read,   12'h00C, 8'h00, 8'h00}, '{op_write,  12'hF00, 8'h77, 8'h00},
        '{op_read,   12'hF00, 8'h00, 8'h00}, '{op_read,   12'h120, 8'h00, 8'h00},
        '{op_fill,   12'h000, 8'h00, 8'h00}, '{op_tiles,  12'h000, 8'h00, 8'h00},
        '{op_scan,   12'h000, 8'h00, 8'h00}, '{op_write,  12'h009, 8'h06, 8'h00},
        '{op_scan,   12'h000, 8'h00, 8'h00}, '{op_write,  12'h009, 8'h00, 8'h00},
        '{op_scan,   12'h000, 8'h00, 8'h00}, '{op_vblank, 12'h000, 8'h00, 8'h01},
        '{op_write,  12'h00A, 8'h01, 8'h00}, '{op_vblank, 12'h000, 8'h00, 8'h00},
        '{op_read,   12'h00B, 8'h00, 8'h01}, '{op_write,  12'h00B, 8'h00, 8'h00},
        '{op_irq,    12'h000, 8'h00, 8'h01}, '{op_vblank, 12'h000, 8'h00, 8'h00},
        '{op_write,  12'h00A, 8'h00, 8'h00}, '{op_irq,    12'h000, 8'h00, 8'h01},
        '{op_vblank, 12'h000, 8'h00, 8'h01}
    };

    logic               clk;
    logic               rst;
    logic               cpu_cs;
    logic               cpu_we;
    gfx_pkg::cpu_addr_t cpu_addr;
    gfx_pkg::cpu_data_t cpu_wdata;
    gfx_pkg::cpu_data_t cpu_rdata;
    logic               irq_n;
    gfx_pkg::video_in_t video_in;
    logic               vblank;
    gfx_pkg::pixel_t    pxl_out;
    logic               pxl_valid;

    // Shadow copy of the registers and tile rows
    gfx_pkg::scroll_t   sh_scroll [gfx_pkg::max_layers];
    gfx_pkg::pixel_t    sh_bg;
    logic [7:0]         sh_en;
    gfx_pkg::cpu_data_t sh_tiles [num_layers][gfx_pkg::tiles_per_row];
    logic [31:0]        rng_state = 32'h9a8ea580;

    tb_clock #(.period_ns(clk_period)) u_clock (.clk(clk));

    gfx_top #(
        .num_layers (num_layers)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .cpu_cs    (cpu_cs),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .irq_n     (irq_n),
        .video_in  (video_in),
        .vblank    (vblank),
        .pxl_out   (pxl_out),
        .pxl_valid (pxl_valid)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic void shadow_write(logic [11:0] addr, logic [7:0] data);
        logic [3:0] page;
        logic [7:0] off;
        page = addr[11:8];
        off  = addr[7:0];
        if (page == 4'd0) begin
            if (off < 8'(num_layers)) begin
                sh_scroll[off[2:0]] = data;
            end else if (off == gfx_pkg::reg_bg) begin
                sh_bg = data;
            end else if (off == gfx_pkg::reg_layer_en) begin
                sh_en = data;
            end
        end else if (int'(page) <= num_layers && off < 8'(gfx_pkg::tiles_per_row)) begin
            sh_tiles[int'(page) - 1][off[4:0]] = data;
        end
    endfunction

    // Lowest enabled layer with a non-zero colour wins, else background
    function automatic gfx_pkg::pixel_t model_pixel(gfx_pkg::video_in_t v);
        gfx_pkg::scroll_t   pos;
        gfx_pkg::cpu_data_t ent;
        gfx_pkg::pixel_t    res;
        logic               found;
        res   = v.active ? sh_bg : 8'h00;
        found = !v.active;
        for (int l = 0; l < num_layers; l++) begin
            pos = v.hpos[7:0] + sh_scroll[l];
            ent = sh_tiles[l][pos[7:3]];
            if (!found && sh_en[l] && ent[3:0] != 4'h0) begin
                res   = ent;
                found = 1'b1;
            end
        end
        return res;
    endfunction

    // All bus tasks start and end on a falling edge
    task automatic bus_write(logic [11:0] addr, logic [7:0] data);
        cpu_cs    = 1'b1;
        cpu_we    = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(negedge clk);
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
        shadow_write(addr, data);
    endtask

    task automatic bus_read(logic [11:0] addr, output logic [7:0] data);
        cpu_cs   = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = addr;
        @(negedge clk);
        data   = cpu_rdata;
        cpu_cs = 1'b0;
    endtask

    task automatic fill_tiles();
        logic [7:0] d;
        for (int l = 0; l < num_layers; l++) begin
            for (int i = 0; i < gfx_pkg::tiles_per_row; i++) begin
                rng_state = xorshift32(rng_state);
                // About a quarter of the tiles are transparent
                d = (rng_state[9:8] == 2'd0) ? {rng_state[7:4], 4'h0} : rng_state[7:0];
                bus_write({4'(l + 1), 8'(i)}, d);
            end
        end
    endtask

    task automatic verify_tiles();
        logic [7:0] d;
        for (int l = 0; l < num_layers; l++) begin
            for (int i = 0; i < gfx_pkg::tiles_per_row; i++) begin
                bus_read({4'(l + 1), 8'(i)}, d);
                compare_value("cpu_rdata", 32'(d), 32'(sh_tiles[l][i]));
            end
        end
    endtask

    // Pixel driven at one falling edge is checked two falling edges later
    task automatic run_scan();
        gfx_pkg::pixel_t    pxl_q [$];
        logic               valid_q [$];
        gfx_pkg::video_in_t v;
        gfx_pkg::pixel_t    want_pxl;
        logic               want_valid;
        for (int i = 0; i < scan_len + 2; i++) begin
            if (i >= 2) begin
                want_pxl   = pxl_q.pop_front();
                want_valid = valid_q.pop_front();
                compare_value("pxl_valid", 32'(pxl_valid), 32'(want_valid));
                compare_value("pxl_out", 32'(pxl_out), 32'(want_pxl));
            end
            v = '0;
            if (i < scan_len) begin
                v.hpos   = 9'(i);
                v.active = (i < active_len);
                pxl_q.push_back(model_pixel(v));
                valid_q.push_back(v.active);
            end
            video_in = v;
            @(negedge clk);
        end
    endtask

    task automatic pulse_vblank(logic [7:0] want);
        vblank = 1'b1;
        @(negedge clk);
        compare_value("irq_n", 32'(irq_n), 32'(want));
        vblank = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        #(timeout_ns);
        $display("Watchdog expired: the table did not finish within %0d ns", timeout_ns);
        $display("Simulation FAILED");
        $fatal(1, "Run timed out");
    end

    initial begin
        logic [7:0] rd;
        rst       = 1'b1;
        cpu_cs    = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        video_in  = '0;
        vblank    = 1'b0;
        sh_bg     = '0;
        sh_en     = 8'hFF;
        for (int l = 0; l < gfx_pkg::max_layers; l++) begin
            sh_scroll[l] = '0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
        compare_value("pxl_valid", 32'(pxl_valid), 32'h0);
        compare_value("pxl_out", 32'(pxl_out), 32'h0);
        compare_value("irq_n", 32'(irq_n), 32'h1);

        for (int s = 0; s < num_steps; s++) begin
            case (steps[s].op)
                op_write:  bus_write(steps[s].addr, steps[s].data);
                op_read: begin
                    bus_read(steps[s].addr, rd);
                    compare_value("cpu_rdata", 32'(rd), 32'(steps[s].exp));
                end
                op_fill:   fill_tiles();
                op_tiles:  verify_tiles();
                op_scan:   run_scan();
                op_vblank: pulse_vblank(steps[s].exp);
                op_irq:    compare_value("irq_n", 32'(irq_n), 32'(steps[s].exp));
                default: ;
            endcase
        end

        repeat (2) @(negedge clk);
        if (dut0.u_props.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/gfx_properties.sv
`default_nettype none

module gfx_properties (
    input logic               clk,
    input logic               rst,
    input gfx_pkg::video_in_t video_in,
    input logic               irq_en,
    input logic               irq_n,
    input gfx_pkg::pixel_t    pxl_out,
    input logic               pxl_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // Two register stages from video input to pixel output
    valid_delay: assert property (@(posedge clk) disable iff (rst)
        pxl_valid == $past(video_in.active, 2))
    else begin
        fail_count++;
        $error("pxl_valid is not active delayed by two cycles");
    end

    irq_masked: assert property (@(posedge clk) disable iff (rst) !irq_en |-> irq_n)
    else begin
        fail_count++;
        $error("irq_n low while irq_en is clear");
    end

    blank_zero: assert property (@(posedge clk) disable iff (rst)
        !pxl_valid |-> pxl_out == '0)
    else begin
        fail_count++;
        $error("pxl_out not zero while pxl_valid is low");
    end

endmodule

bind gfx_top gfx_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .video_in  (video_in),
    .irq_en    (u_regs.irq_en_q),
    .irq_n     (irq_n),
    .pxl_out   (pxl_out),
    .pxl_valid (pxl_valid)
);

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // Starts low so the first rising edge is half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: source/gfx_top.sv
`default_nettype none

module gfx_top #(
    parameter int num_layers = 3
) (
    input  logic                clk,
    input  logic                rst,
    // CPU bus
    input  logic                cpu_cs,
    input  logic                cpu_we,
    input  gfx_pkg::cpu_addr_t  cpu_addr,
    input  gfx_pkg::cpu_data_t  cpu_wdata,
    output gfx_pkg::cpu_data_t  cpu_rdata,
    output logic                irq_n,
    // Video timing in, pixels out
    input  gfx_pkg::video_in_t  video_in,
    input  logic                vblank,
    output gfx_pkg::pixel_t     pxl_out,
    output logic                pxl_valid
);

    gfx_pkg::tile_bus_t   tile_bus [num_layers];
    gfx_pkg::cpu_data_t   tile_rdata [num_layers];
    gfx_pkg::layer_cfg_t  layer_cfg [num_layers];
    gfx_pkg::layer_pxl_t  layer_pxl [num_layers];
    // Only layer 0's flag feeds the mixer
    logic                 layer_active [num_layers];
    gfx_pkg::pixel_t      bg_pxl;

    gfx_regs #(
        .num_layers (num_layers)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .cpu_cs     (cpu_cs),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rdata  (cpu_rdata),
        .vblank     (vblank),
        .irq_n      (irq_n),
        .tile_bus   (tile_bus),
        .tile_rdata (tile_rdata),
        .layer_cfg  (layer_cfg),
        .bg_pxl     (bg_pxl)
    );

    for (genvar l = 0; l < num_layers; l++) begin : gen_layer
        layer_unit u_layer (
            .clk        (clk),
            .rst        (rst),
            .tile_bus   (tile_bus[l]),
            .tile_rdata (tile_rdata[l]),
            .cfg        (layer_cfg[l]),
            .video      (video_in),
            .pxl        (layer_pxl[l]),
            .active     (layer_active[l])
        );
    end

    layer_mixer #(
        .num_layers (num_layers)
    ) u_mixer (
        .clk        (clk),
        .rst        (rst),
        .layer_pxl  (layer_pxl),
        .active     (layer_active[0]),
        .bg_pxl     (bg_pxl),
        .pxl_out    (pxl_out),
        .pxl_valid  (pxl_valid)
    );

endmodule

`default_nettype wire

// File: source/layer_mixer.sv
`default_nettype none

module layer_mixer #(
    parameter int num_layers = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  gfx_pkg::layer_pxl_t  layer_pxl [num_layers],
    input  logic                 active,
    input  gfx_pkg::pixel_t      bg_pxl,
    output gfx_pkg::pixel_t      pxl_out,
    output logic                 pxl_valid
);

    gfx_pkg::pixel_t sel_pxl;

    // Walk from the top index down so layer 0 has the last word
    always_comb begin
        sel_pxl = bg_pxl;
        for (int l = num_layers - 1; l >= 0; l--) begin
            if (layer_pxl[l].col != '0) begin
                sel_pxl = gfx_pkg::pixel_t'(layer_pxl[l]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_out   <= '0;
            pxl_valid <= 1'b0;
        end else begin
            pxl_valid <= active;
            // Blanked pixels go out as zero
            if (active) begin
                pxl_out <= sel_pxl;
            end else begin
                pxl_out <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/layer_unit.sv
`default_nettype none

module layer_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  gfx_pkg::tile_bus_t   tile_bus,
    output gfx_pkg::cpu_data_t   tile_rdata,
    input  gfx_pkg::layer_cfg_t  cfg,
    input  gfx_pkg::video_in_t   video,
    output gfx_pkg::layer_pxl_t  pxl,
    output logic                 active
);

    // Entry is palette in the high nibble, colour in the low one
    gfx_pkg::cpu_data_t tile_mem [gfx_pkg::tiles_per_row];

    gfx_pkg::scroll_t   scr_pos;
    gfx_pkg::tile_idx_t render_idx;
    gfx_pkg::cpu_data_t entry;

    // CPU port, read-before-write
    always_ff @(posedge clk) begin
        if (tile_bus.we) begin
            tile_mem[tile_bus.idx] <= tile_bus.wdata;
        end
        tile_rdata <= tile_mem[tile_bus.idx];
    end

    // Scroll wraps at 256, eight pixels per tile
    assign scr_pos    = video.hpos[7:0] + cfg.scroll;
    assign render_idx = scr_pos[7:3];
    assign entry      = tile_mem[render_idx];

    // Render port
    always_ff @(posedge clk) begin
        pxl.pal <= entry[7:4];
        if (cfg.en) begin
            pxl.col <= entry[3:0];
        end else begin
            pxl.col <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
        end else begin
            active <= video.active;
        end
    end

endmodule

`default_nettype wire

// File: source/gfx_regs.sv
`default_nettype none

module gfx_regs #(
    parameter int num_layers = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_cs,
    input  logic                 cpu_we,
    input  gfx_pkg::cpu_addr_t   cpu_addr,
    input  gfx_pkg::cpu_data_t   cpu_wdata,
    output gfx_pkg::cpu_data_t   cpu_rdata,
    input  logic                 vblank,
    output logic                 irq_n,
    output gfx_pkg::tile_bus_t   tile_bus [num_layers],
    input  gfx_pkg::cpu_data_t   tile_rdata [num_layers],
    output gfx_pkg::layer_cfg_t  layer_cfg [num_layers],
    output gfx_pkg::pixel_t      bg_pxl
);

    logic [3:0] page;
    logic [7:0] offset;
    logic       wr_stb;
    logic       rd_stb;
    logic       reg_wr;
    logic       ack_wr;
    logic       ctrl_off_wr;
    logic       tile_off_ok;
    logic       rd_map;

    gfx_pkg::scroll_t               scroll_q [num_layers];
    logic [gfx_pkg::max_layers-1:0] layer_en_q;
    gfx_pkg::pixel_t                bg_q;
    logic                           irq_en_q;
    logic                           irq_pend;
    logic                           vblank_q;

    gfx_pkg::cpu_data_t reg_rd;
    gfx_pkg::cpu_data_t rd_reg_q;
    gfx_pkg::cpu_data_t rd_now;
    gfx_pkg::cpu_data_t rd_hold;
    logic [3:0]         rd_page_q;
    logic               rd_map_q;
    logic               rd_pend;

    assign page        = cpu_addr[11:8];
    assign offset      = cpu_addr[7:0];
    assign wr_stb      = cpu_cs & cpu_we;
    assign rd_stb      = cpu_cs & ~cpu_we;
    assign reg_wr      = wr_stb && (page == 4'd0);
    assign ack_wr      = reg_wr && (offset == gfx_pkg::reg_irq_ack);
    assign ctrl_off_wr = reg_wr && (offset == gfx_pkg::reg_ctrl) && !cpu_wdata[0];

    // Tile pages only decode the first 32 offsets
    assign tile_off_ok = (offset[7:5] == 3'd0);
    assign rd_map      = (page == 4'd0) || (page <= 4'(num_layers) && tile_off_ok);

    // Configuration registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < num_layers; l++) begin
                scroll_q[l] <= '0;
            end
            layer_en_q <= '1;
            bg_q       <= '0;
            irq_en_q   <= 1'b0;
        end else if (reg_wr) begin
            for (int l = 0; l < num_layers; l++) begin
                if (offset == gfx_pkg::reg_scroll_base + 8'(l)) begin
                    scroll_q[l] <= cpu_wdata;
                end
            end
            case (offset)
                gfx_pkg::reg_bg:       bg_q       <= cpu_wdata;
                gfx_pkg::reg_layer_en: layer_en_q <= cpu_wdata;
                gfx_pkg::reg_ctrl:     irq_en_q   <= cpu_wdata[0];
                default: ;
            endcase
        end
    end

    // Vblank edge sets the pending flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vblank_q <= 1'b0;
            irq_pend <= 1'b0;
        end else begin
            vblank_q <= vblank;
            // Ack or clearing irq_en drops the flag on the write edge
            if (ack_wr || ctrl_off_wr || !irq_en_q) begin
                irq_pend <= 1'b0;
            end else if (vblank && !vblank_q) begin
                irq_pend <= 1'b1;
            end
        end
    end

    assign irq_n = ~irq_pend;

    // Register read-back is sampled in the read cycle
    always_comb begin
        reg_rd = '0;
        for (int l = 0; l < num_layers; l++) begin
            if (offset == gfx_pkg::reg_scroll_base + 8'(l)) begin
                reg_rd = scroll_q[l];
            end
        end
        case (offset)
            gfx_pkg::reg_bg:       reg_rd = bg_q;
            gfx_pkg::reg_layer_en: reg_rd = layer_en_q;
            gfx_pkg::reg_ctrl:     reg_rd = {7'd0, irq_en_q};
            gfx_pkg::reg_irq_ack:  reg_rd = {7'd0, irq_pend};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_stb) begin
            rd_page_q <= page;
            rd_map_q  <= rd_map;
            rd_reg_q  <= reg_rd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pend <= 1'b0;
            rd_hold <= '0;
        end else begin
            rd_pend <= rd_stb;
            rd_hold <= cpu_rdata;
        end
    end

    // Tile RAM data arrives one cycle after the read
    always_comb begin
        rd_now = '0;
        if (rd_map_q) begin
            if (rd_page_q == 4'd0) begin
                rd_now = rd_reg_q;
            end
            for (int l = 0; l < num_layers; l++) begin
                if (rd_page_q == 4'(l + 1)) begin
                    rd_now = tile_rdata[l];
                end
            end
        end
    end

    // Hold the last result until the next read
    assign cpu_rdata = rd_pend ? rd_now : rd_hold;

    always_comb begin
        for (int l = 0; l < num_layers; l++) begin
            tile_bus[l].we      = wr_stb && tile_off_ok && (page == 4'(l + 1));
            tile_bus[l].idx     = cpu_addr[4:0];
            tile_bus[l].wdata   = cpu_wdata;
            layer_cfg[l].scroll = scroll_q[l];
            layer_cfg[l].en     = layer_en_q[l];
        end
    end

    assign bg_pxl = bg_q;

endmodule

`default_nettype wire

// File: source/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

    localparam int max_layers    = 8;
    localparam int tiles_per_row = 32;

    typedef logic [11:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [8:0]  hpos_t;
    typedef logic [7:0]  scroll_t;
    typedef logic [4:0]  tile_idx_t;
    // Colour zero is transparent
    typedef logic [3:0]  colour_t;
    typedef logic [3:0]  palette_t;
    typedef logic [7:0]  pixel_t;

    // Page 0 register offsets
    localparam logic [7:0] reg_scroll_base = 8'h00;
    localparam logic [7:0] reg_bg          = 8'h08;
    localparam logic [7:0] reg_layer_en    = 8'h09;
    localparam logic [7:0] reg_ctrl        = 8'h0A;
    localparam logic [7:0] reg_irq_ack     = 8'h0B;

    // CPU side of one layer's tile RAM
    typedef struct packed {
        logic      we;
        tile_idx_t idx;
        cpu_data_t wdata;
    } tile_bus_t;

    typedef struct packed {
        logic    en;
        scroll_t scroll;
    } layer_cfg_t;

    // Same layout as pixel_t
    typedef struct packed {
        palette_t pal;
        colour_t  col;
    } layer_pxl_t;

    typedef struct packed {
        logic  active;
        hpos_t hpos;
    } video_in_t;

endpackage

`default_nettype wire
